// ==== common/fabric_pkg.sv ====
`default_nettype none

package fabric_pkg;

   localparam int unsigned NUM_TILES = 4;
   localparam int unsigned TILE_W    = $clog2(NUM_TILES);
   localparam int unsigned CFG_W     = 16; // One config word, route or LUT

   // Source of one switch box output
   typedef enum logic [1:0] {
      ROUTE_STRAIGHT = 2'd0, // Opposite side, same track
      ROUTE_TURN_A   = 2'd1,
      ROUTE_TURN_B   = 2'd2,
      ROUTE_LOCAL    = 2'd3  // Tile logic block
   } route_sel_t;

   localparam int unsigned SEL_W = $bits(route_sel_t);

   // Selector offsets inside the routing word
   localparam int unsigned FLD_LEFT_0   = 0;
   localparam int unsigned FLD_LEFT_2   = 2;
   localparam int unsigned FLD_RIGHT_1  = 4;
   localparam int unsigned FLD_RIGHT_3  = 6;
   localparam int unsigned FLD_TOP_1    = 8;
   localparam int unsigned FLD_TOP_3    = 10;
   localparam int unsigned FLD_BOTTOM_0 = 12;
   localparam int unsigned FLD_BOTTOM_2 = 14;

endpackage

`default_nettype wire

// ==== common/wb_cfg_pkg.sv ====
`default_nettype none

package wb_cfg_pkg;

   localparam int unsigned WB_ADR_W = 5; // Word address

   // Word address = tile * 2 + kind
   localparam int unsigned NUM_KINDS     = 2;
   localparam int unsigned KIND_BIT      = 0;
   localparam int unsigned TILE_LSB      = 1;
   localparam int unsigned NUM_CFG_WORDS = fabric_pkg::NUM_TILES * NUM_KINDS;

   // Which config target inside a tile
   typedef enum logic {
      CFG_ROUTE = 1'b0, // Switch box routing word
      CFG_LUT   = 1'b1  // Logic block truth table
   } cfg_kind_t;

endpackage

`default_nettype wire

// ==== common/cfg_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface cfg_if ();
   import fabric_pkg::*;
   import wb_cfg_pkg::*;

   logic [TILE_W-1:0] cfg_tile;
   cfg_kind_t         cfg_kind;
   logic [CFG_W-1:0]  cfg_wdata;
   logic              cfg_we;
   logic [CFG_W-1:0]  cfg_rdata [NUM_TILES][NUM_KINDS]; // Each target owns one slot

   modport master (output cfg_tile, cfg_kind, cfg_wdata, cfg_we, input cfg_rdata);
   modport target (input cfg_tile, cfg_kind, cfg_wdata, cfg_we, output cfg_rdata);

endinterface

`default_nettype wire

// ==== switch_box/switch_box.sv ====
`timescale 1ns/1ps
`default_nettype none

module switch_box #(
   parameter int unsigned TILE_ID = 0
) (
   input  logic  clk,
   input  logic  arst_n,

   output logic  left_0,
   input  logic  left_1,
   output logic  left_2,
   input  logic  left_3,

   input  logic  right_0,
   output logic  right_1,
   input  logic  right_2,
   output logic  right_3,

   input  logic  top_0,
   output logic  top_1,
   input  logic  top_2,
   output logic  top_3,

   output logic  bottom_0,
   input  logic  bottom_1,
   output logic  bottom_2,
   input  logic  bottom_3,

   input  logic  lb_out,
   cfg_if.target cfg
);
   import fabric_pkg::*;
   import wb_cfg_pkg::*;

   logic [CFG_W-1:0] route_word;

   function automatic logic pick(input route_sel_t sel, input logic straight,
                                 input logic turn_a, input logic turn_b,
                                 input logic local_in);
      logic res;
      case (sel)
         ROUTE_STRAIGHT: res = straight;
         ROUTE_TURN_A:   res = turn_a;
         ROUTE_TURN_B:   res = turn_b;
         ROUTE_LOCAL:    res = local_in;
      endcase
      return res;
   endfunction

   always_ff @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
         route_word <= '0; // All straight
      else if (cfg.cfg_we && cfg.cfg_tile == TILE_W'(TILE_ID) && cfg.cfg_kind == CFG_ROUTE)
         route_word <= cfg.cfg_wdata;
   end

   assign cfg.cfg_rdata[TILE_ID][CFG_ROUTE] = route_word;

   // Westward outputs never see west inputs, eastward never east
   assign left_0   = pick(route_sel_t'(route_word[FLD_LEFT_0 +: SEL_W]),
                          right_0, top_0, bottom_1, lb_out);
   assign left_2   = pick(route_sel_t'(route_word[FLD_LEFT_2 +: SEL_W]),
                          right_2, top_2, bottom_3, lb_out);
   assign right_1  = pick(route_sel_t'(route_word[FLD_RIGHT_1 +: SEL_W]),
                          left_1, top_0, bottom_1, lb_out);
   assign right_3  = pick(route_sel_t'(route_word[FLD_RIGHT_3 +: SEL_W]),
                          left_3, top_2, bottom_3, lb_out);
   assign top_1    = pick(route_sel_t'(route_word[FLD_TOP_1 +: SEL_W]),
                          bottom_1, left_1, right_0, lb_out);
   assign top_3    = pick(route_sel_t'(route_word[FLD_TOP_3 +: SEL_W]),
                          bottom_3, left_3, right_2, lb_out);
   assign bottom_0 = pick(route_sel_t'(route_word[FLD_BOTTOM_0 +: SEL_W]),
                          top_0, left_1, right_0, lb_out);
   assign bottom_2 = pick(route_sel_t'(route_word[FLD_BOTTOM_2 +: SEL_W]),
                          top_2, left_3, right_2, lb_out);

   // Neighbour tiles and the logic block must keep every track resolved
   a_no_x_out: assert property (@(posedge clk) disable iff (!arst_n)
      !$isunknown({left_0, left_2, right_1, right_3, top_1, top_3, bottom_0, bottom_2}))
      else $error("switch_box %0d drives an unknown output", TILE_ID);

endmodule

`default_nettype wire

// ==== logic_block/logic_block.sv ====
`timescale 1ns/1ps
`default_nettype none

module logic_block #(
   parameter int unsigned TILE_ID = 0
) (
   input  logic       clk,
   input  logic       arst_n,
   input  logic [3:0] lut_in,
   output logic       lut_out,
   cfg_if.target      cfg
);
   import fabric_pkg::*;
   import wb_cfg_pkg::*;

   logic [CFG_W-1:0] truth;
   logic             hit;

   // Write addressed to this tile's LUT
   assign hit = cfg.cfg_we && cfg.cfg_tile == TILE_W'(TILE_ID) && cfg.cfg_kind == CFG_LUT;

   always_ff @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
         truth <= '0;
      else if (hit)
         truth <= cfg.cfg_wdata;
   end

   // Registered output breaks any path back into the routing
   always_ff @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
         lut_out <= 1'b0;
      else
         lut_out <= truth[lut_in];
   end

   assign cfg.cfg_rdata[TILE_ID][CFG_LUT] = truth;

   a_out_clear: assert property (@(posedge clk) $rose(arst_n) |=> lut_out == 1'b0)
      else $error("logic_block %0d output not cleared by reset", TILE_ID);

endmodule

`default_nettype wire

// ==== rtl/cfg_loader.sv ====
`timescale 1ns/1ps
`default_nettype none

module cfg_loader (
   input  logic                            clk,
   input  logic                            arst_n,
   input  logic                            wb_cyc,
   input  logic                            wb_stb,
   input  logic                            wb_we,
   input  logic [wb_cfg_pkg::WB_ADR_W-1:0] wb_adr,
   input  logic [fabric_pkg::CFG_W-1:0]    wb_dat_w,
   output logic [fabric_pkg::CFG_W-1:0]    wb_dat_r,
   output logic                            wb_ack,
   cfg_if.master                           cfg
);
   import fabric_pkg::*;
   import wb_cfg_pkg::*;

   logic              req;
   logic              in_range;
   logic [TILE_W-1:0] adr_tile;
   cfg_kind_t         adr_kind;

   // No new request while acking, so acks stay one cycle apart
   assign req      = wb_cyc && wb_stb && !wb_ack;
   assign in_range = wb_adr < WB_ADR_W'(NUM_CFG_WORDS);

   assign adr_tile = wb_adr[TILE_LSB +: TILE_W];
   assign adr_kind = cfg_kind_t'(wb_adr[KIND_BIT]);

   assign cfg.cfg_tile  = adr_tile;
   assign cfg.cfg_kind  = adr_kind;
   assign cfg.cfg_wdata = wb_dat_w;
   assign cfg.cfg_we    = req && wb_we && in_range; // Targets latch on the ack edge

   always_ff @(posedge clk or negedge arst_n)
   begin
      if (!arst_n)
         wb_ack <= 1'b0;
      else
         wb_ack <= req;
   end

   // Readback captured with ack, out-of-range reads zero
   always_ff @(posedge clk)
   begin
      if (req && !wb_we)
      begin
         if (in_range)
            wb_dat_r <= cfg.cfg_rdata[adr_tile][adr_kind];
         else
            wb_dat_r <= '0;
      end
   end

   a_ack_single: assert property (@(posedge clk) disable iff (!arst_n)
      wb_ack |=> !wb_ack)
      else $error("wb_ack held for two cycles");

   a_ack_after_req: assert property (@(posedge clk) disable iff (!arst_n)
      $rose(wb_ack) |-> $past(wb_cyc && wb_stb))
      else $error("wb_ack without a preceding request");

endmodule

`default_nettype wire

// ==== rtl/fabric_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module fabric_top (
   input  logic                                clk,
   input  logic                                arst_n,

   input  logic                                wb_cyc,
   input  logic                                wb_stb,
   input  logic                                wb_we,
   input  logic [wb_cfg_pkg::WB_ADR_W-1:0]     wb_adr,
   input  logic [fabric_pkg::CFG_W-1:0]        wb_dat_w,
   output logic [fabric_pkg::CFG_W-1:0]        wb_dat_r,
   output logic                                wb_ack,

   input  logic [1:0]                          west_in,
   output logic [1:0]                          west_out,
   input  logic [1:0]                          east_in,
   output logic [1:0]                          east_out,
   input  logic [2*fabric_pkg::NUM_TILES-1:0]  north_in,
   output logic [2*fabric_pkg::NUM_TILES-1:0]  north_out,
   input  logic [2*fabric_pkg::NUM_TILES-1:0]  south_in,
   output logic [2*fabric_pkg::NUM_TILES-1:0]  south_out
);
   import fabric_pkg::*;

   // Index i is the left edge of tile i, tracks 1/3 run east and 0/2 run west
   logic [NUM_TILES:0]   east_1;
   logic [NUM_TILES:0]   east_3;
   logic [NUM_TILES:0]   west_0;
   logic [NUM_TILES:0]   west_2;
   logic [NUM_TILES-1:0] lb_out;

   cfg_if cfg_bus ();

   cfg_loader u_loader (
      .clk      (clk),
      .arst_n   (arst_n),
      .wb_cyc   (wb_cyc),
      .wb_stb   (wb_stb),
      .wb_we    (wb_we),
      .wb_adr   (wb_adr),
      .wb_dat_w (wb_dat_w),
      .wb_dat_r (wb_dat_r),
      .wb_ack   (wb_ack),
      .cfg      (cfg_bus)
   );

   assign east_1[0]         = west_in[0];
   assign east_3[0]         = west_in[1];
   assign west_0[NUM_TILES] = east_in[0];
   assign west_2[NUM_TILES] = east_in[1];

   assign west_out = {west_2[0], west_0[0]};
   assign east_out = {east_3[NUM_TILES], east_1[NUM_TILES]};

   for (genvar i = 0; i < NUM_TILES; i++)
   begin : g_tile
      switch_box #(.TILE_ID(i)) u_sb (
         .clk      (clk),
         .arst_n   (arst_n),
         .left_0   (west_0[i]),
         .left_1   (east_1[i]),
         .left_2   (west_2[i]),
         .left_3   (east_3[i]),
         .right_0  (west_0[i+1]),
         .right_1  (east_1[i+1]),
         .right_2  (west_2[i+1]),
         .right_3  (east_3[i+1]),
         .top_0    (north_in[2*i]),
         .top_1    (north_out[2*i]),
         .top_2    (north_in[2*i+1]),
         .top_3    (north_out[2*i+1]),
         .bottom_0 (south_out[2*i]),
         .bottom_1 (south_in[2*i]),
         .bottom_2 (south_out[2*i+1]),
         .bottom_3 (south_in[2*i+1]),
         .lb_out   (lb_out[i]),
         .cfg      (cfg_bus)
      );

      // LUT inputs 0..3 are left_1, right_0, top_0, bottom_1
      logic_block #(.TILE_ID(i)) u_lb (
         .clk     (clk),
         .arst_n  (arst_n),
         .lut_in  ({south_in[2*i], north_in[2*i], west_0[i+1], east_1[i]}),
         .lut_out (lb_out[i]),
         .cfg     (cfg_bus)
      );
   end

endmodule

`default_nettype wire

// ==== testbench/fabric_model.svh ====
`ifndef FABRIC_MODEL_SVH
`define FABRIC_MODEL_SVH

// Used for the edge inputs and for the edge outputs alike
typedef struct packed {
   logic [1:0]             west;
   logic [1:0]             east;
   logic [2*NUM_TILES-1:0] north;
   logic [2*NUM_TILES-1:0] south;
} pin_set_t;

typedef struct packed {
   logic [NUM_TILES-1:0][CFG_W-1:0] route;
   logic [NUM_TILES-1:0][CFG_W-1:0] lut;
   pin_set_t                        pins_a;   // Held for one cycle, loads the LUT registers
   pin_set_t                        pins_b;   // Present on the checked cycle
   pin_set_t                        expected;
} entry_t;

// src holds {local, turn B, turn A, straight}
function automatic logic field_src(input logic [CFG_W-1:0] word, input int fld,
                                   input logic [3:0] src);
   return src[word[fld +: 2]];
endfunction

// Whole row, eastward tracks first, then westward, then the vertical outputs
function automatic pin_set_t route_row(input logic [NUM_TILES-1:0][CFG_W-1:0] route,
                                       input pin_set_t pin, input logic [NUM_TILES-1:0] lb,
                                       output logic [NUM_TILES-1:0][3:0] lut_idx);
   logic [NUM_TILES:0] e1;
   logic [NUM_TILES:0] e3;
   logic [NUM_TILES:0] w0;
   logic [NUM_TILES:0] w2;
   pin_set_t           res;
   e1[0] = pin.west[0];
   e3[0] = pin.west[1];
   w0[NUM_TILES] = pin.east[0];
   w2[NUM_TILES] = pin.east[1];
   for (int i = 0; i < NUM_TILES; i++)
   begin
      e1[i+1] = field_src(route[i], FLD_RIGHT_1, {lb[i], pin.south[2*i], pin.north[2*i], e1[i]});
      e3[i+1] = field_src(route[i], FLD_RIGHT_3,
                          {lb[i], pin.south[2*i+1], pin.north[2*i+1], e3[i]});
   end
   for (int i = NUM_TILES - 1; i >= 0; i--)
   begin
      w0[i] = field_src(route[i], FLD_LEFT_0, {lb[i], pin.south[2*i], pin.north[2*i], w0[i+1]});
      w2[i] = field_src(route[i], FLD_LEFT_2,
                        {lb[i], pin.south[2*i+1], pin.north[2*i+1], w2[i+1]});
   end
   for (int i = 0; i < NUM_TILES; i++)
   begin
      res.north[2*i]   = field_src(route[i], FLD_TOP_1, {lb[i], w0[i+1], e1[i], pin.south[2*i]});
      res.north[2*i+1] = field_src(route[i], FLD_TOP_3,
                                   {lb[i], w2[i+1], e3[i], pin.south[2*i+1]});
      res.south[2*i]   = field_src(route[i], FLD_BOTTOM_0,
                                   {lb[i], w0[i+1], e1[i], pin.north[2*i]});
      res.south[2*i+1] = field_src(route[i], FLD_BOTTOM_2,
                                   {lb[i], w2[i+1], e3[i], pin.north[2*i+1]});
      lut_idx[i] = {pin.south[2*i], pin.north[2*i], w0[i+1], e1[i]};
   end
   res.west = {w2[0], w0[0]};
   res.east = {e3[NUM_TILES], e1[NUM_TILES]};
   return res;
endfunction

// LUT register values one clock after pin is applied
function automatic logic [NUM_TILES-1:0] lut_capture(
      input logic [NUM_TILES-1:0][CFG_W-1:0] route,
      input logic [NUM_TILES-1:0][CFG_W-1:0] lut, input pin_set_t pin);
   logic [NUM_TILES-1:0][3:0] idx;
   logic [NUM_TILES-1:0]      lb;
   void'(route_row(route, pin, '0, idx));
   for (int t = 0; t < NUM_TILES; t++)
      lb[t] = lut[t][idx[t]];
   return lb;
endfunction

`endif

// ==== testbench/fabric_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module fabric_tb;
   import fabric_pkg::*;
   import wb_cfg_pkg::*;

   `include "fabric_model.svh"

   localparam int NUM_ENTRIES  = 12;
   localparam int RESET_CYCLES = 2;
   // Nine writes and nine reads of three cycles each, then the pin cycles
   localparam int ENTRY_CYCLES = 2 * 3 * (NUM_CFG_WORDS + 1) + 4;
   localparam int CYCLE_LIMIT  = NUM_ENTRIES * ENTRY_CYCLES + RESET_CYCLES + 10;

   logic                   clk;
   logic                   arst_n;
   logic                   wb_cyc;
   logic                   wb_stb;
   logic                   wb_we;
   logic [WB_ADR_W-1:0]    wb_adr;
   logic [CFG_W-1:0]       wb_dat_w;
   logic [CFG_W-1:0]       wb_dat_r;
   logic                   wb_ack;
   logic [1:0]             west_in;
   logic [1:0]             west_out;
   logic [1:0]             east_in;
   logic [1:0]             east_out;
   logic [2*NUM_TILES-1:0] north_in;
   logic [2*NUM_TILES-1:0] north_out;
   logic [2*NUM_TILES-1:0] south_in;
   logic [2*NUM_TILES-1:0] south_out;

   int          cycles;
   int          entry_checks;
   int          entry_errors;
   int          total_checks;
   int          total_errors;
   logic [31:0] rng;
   entry_t      tests [NUM_ENTRIES];
   string       test_name [NUM_ENTRIES];

   fabric_top u_dut (.*);

   initial
   begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   initial
   begin
      cycles = 0;
      while (cycles < CYCLE_LIMIT)
      begin
         @(posedge clk);
         cycles++;
      end
      $display("Timeout: run did not finish within %0d cycles", cycles);
      $display("*** FAILED ***");
      $finish;
   end

   function automatic logic [31:0] xorshift(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   function automatic logic [CFG_W-1:0] random_route(input logic [31:0] r);
      logic [CFG_W-1:0] w;
      for (int f = 0; f < 8; f++)
         w[2*f +: 2] = 2'(r[4*f +: 4] % 4'd3); // Straight or a turn, never local
      return w;
   endfunction

   function automatic logic [WB_ADR_W-1:0] cfg_addr(input int tile, input cfg_kind_t kind);
      return WB_ADR_W'(tile * 2 + int'(kind));
   endfunction

   task automatic check_value(input string name, input logic [CFG_W-1:0] got,
                              input logic [CFG_W-1:0] exp);
      entry_checks++;
      if (got !== exp)
      begin
         entry_errors++;
         $display("Error: %s is %h, expected %h", name, got, exp);
      end
   endtask

   task automatic wait_ack();
      @(negedge clk);
      while (!wb_ack)
         @(negedge clk);
   endtask

   task automatic wb_write(input logic [WB_ADR_W-1:0] adr, input logic [CFG_W-1:0] data);
      @(posedge clk);
      wb_cyc   <= 1'b1;
      wb_stb   <= 1'b1;
      wb_we    <= 1'b1;
      wb_adr   <= adr;
      wb_dat_w <= data;
      wait_ack();
      @(posedge clk);
      wb_cyc <= 1'b0;
      wb_stb <= 1'b0;
      wb_we  <= 1'b0;
   endtask

   task automatic wb_read(input logic [WB_ADR_W-1:0] adr, output logic [CFG_W-1:0] data);
      @(posedge clk);
      wb_cyc <= 1'b1;
      wb_stb <= 1'b1;
      wb_we  <= 1'b0;
      wb_adr <= adr;
      wait_ack();
      data = wb_dat_r; // Valid while ack is high
      @(posedge clk);
      wb_cyc <= 1'b0;
      wb_stb <= 1'b0;
   endtask

   task automatic drive_pins(input pin_set_t p);
      west_in  <= p.west;
      east_in  <= p.east;
      north_in <= p.north;
      south_in <= p.south;
   endtask

   task automatic build_table();
      logic [NUM_TILES-1:0]      lb;
      logic [NUM_TILES-1:0][3:0] idx;
      logic [CFG_W-1:0]          lb_route;
      lb_route = (CFG_W'(ROUTE_LOCAL) << FLD_BOTTOM_0) | (CFG_W'(ROUTE_LOCAL) << FLD_BOTTOM_2);
      for (int e = 0; e < NUM_ENTRIES; e++)
      begin
         tests[e] = '0;
         rng = xorshift(rng);
         tests[e].pins_a = pin_set_t'(rng[19:0]);
         rng = xorshift(rng);
         tests[e].pins_b = pin_set_t'(rng[19:0]);
         for (int t = 0; t < NUM_TILES; t++)
         begin
            rng = xorshift(rng);
            tests[e].lut[t] = rng[31:16]; // Not seen on pins unless routed local
         end
      end
      test_name[0]    = "straight after reset";
      tests[0].lut    = '0;
      test_name[1]    = "all turn A";
      tests[1].route  = {NUM_TILES{16'h5555}};
      test_name[2]    = "all turn B";
      tests[2].route  = {NUM_TILES{16'haaaa}};
      test_name[3]    = "alternating turns";
      tests[3].route  = {16'haaaa, 16'h5555, 16'haaaa, 16'h5555};
      test_name[4]    = "alternating turns swapped";
      tests[4].route  = {16'h5555, 16'haaaa, 16'h5555, 16'haaaa};
      test_name[5]    = "chains turn at the far tiles";
      tests[5].route[3] = CFG_W'(ROUTE_TURN_A) << FLD_TOP_1;
      tests[5].route[0] = CFG_W'(ROUTE_TURN_B) << FLD_BOTTOM_0;
      test_name[6]    = "chains turn at the inner tiles";
      tests[6].route[2] = CFG_W'(ROUTE_TURN_A) << FLD_TOP_3;
      tests[6].route[1] = CFG_W'(ROUTE_TURN_B) << FLD_BOTTOM_2;
      for (int e = 7; e < 10; e++)
      begin
         test_name[e]   = "LUT to south pins";
         tests[e].route = {NUM_TILES{lb_route}};
         tests[e].lut   = {16'h6996, 16'hffff, 16'h6996, 16'h8000}; // XOR, one, XOR, AND
      end
      tests[7].pins_a = '1; // Makes the AND true
      for (int e = 10; e < NUM_ENTRIES; e++)
      begin
         test_name[e] = "random routing";
         for (int t = 0; t < NUM_TILES; t++)
         begin
            rng = xorshift(rng);
            tests[e].route[t] = random_route(rng);
         end
      end
      for (int e = 0; e < NUM_ENTRIES; e++)
      begin
         lb = lut_capture(tests[e].route, tests[e].lut, tests[e].pins_a);
         tests[e].expected = route_row(tests[e].route, tests[e].pins_b, lb, idx);
      end
   endtask

   task automatic run_entry(input int e);
      logic [WB_ADR_W-1:0] oor_adr;
      logic [CFG_W-1:0]    data;
      entry_checks = 0;
      entry_errors = 0;
      oor_adr = WB_ADR_W'(NUM_CFG_WORDS + e);
      // Entry 0 sees the config words as reset left them
      if (e > 0)
      begin
         for (int t = 0; t < NUM_TILES; t++)
         begin
            wb_write(cfg_addr(t, CFG_ROUTE), tests[e].route[t]);
            wb_write(cfg_addr(t, CFG_LUT), tests[e].lut[t]);
         end
      end
      wb_write(oor_adr, 16'hdead ^ CFG_W'(e));
      wb_read(oor_adr, data);
      check_value("wb_dat_r out of range", data, '0);
      for (int t = 0; t < NUM_TILES; t++)
      begin
         wb_read(cfg_addr(t, CFG_ROUTE), data);
         check_value("wb_dat_r route word", data, tests[e].route[t]);
         wb_read(cfg_addr(t, CFG_LUT), data);
         check_value("wb_dat_r LUT word", data, tests[e].lut[t]);
      end
      @(posedge clk);
      drive_pins(tests[e].pins_a);
      @(posedge clk);
      drive_pins(tests[e].pins_b);
      @(negedge clk);
      check_value("west_out", CFG_W'(west_out), CFG_W'(tests[e].expected.west));
      check_value("east_out", CFG_W'(east_out), CFG_W'(tests[e].expected.east));
      check_value("north_out", CFG_W'(north_out), CFG_W'(tests[e].expected.north));
      check_value("south_out", CFG_W'(south_out), CFG_W'(tests[e].expected.south));
      total_checks += entry_checks;
      total_errors += entry_errors;
      $display("Test %0d %s: %0d checks, %0d errors", e, test_name[e], entry_checks,
               entry_errors);
   endtask

   initial
   begin
      arst_n       = 1'b0;
      wb_cyc       = 1'b0;
      wb_stb       = 1'b0;
      wb_we        = 1'b0;
      wb_adr       = '0;
      wb_dat_w     = '0;
      west_in      = '0;
      east_in      = '0;
      north_in     = '0;
      south_in     = '0;
      total_checks = 0;
      total_errors = 0;
      rng          = 32'h6c86;
      build_table();
      repeat (RESET_CYCLES) @(posedge clk);
      arst_n <= 1'b1;
      for (int e = 0; e < NUM_ENTRIES; e++)
         run_entry(e);
      $display("Checks %0d, errors %0d", total_checks, total_errors);
      if (total_errors == 0)
         $display("*** PASSED ***");
      else
         $display("*** FAILED ***");
      $finish;
   end

endmodule

`default_nettype wire

// ==== src.f ====
+incdir+testbench
common/fabric_pkg.sv
common/wb_cfg_pkg.sv
common/cfg_if.sv
switch_box/switch_box.sv
logic_block/logic_block.sv
rtl/cfg_loader.sv
rtl/fabric_top.sv
testbench/fabric_tb.sv

// ==== Makefile ====
SIM      = verilator
FLAGS    = --binary --timing --assert -j 0
TOP      = fabric_tb
FILELIST = src.f
OBJ_DIR  = obj_dir
LOG      = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and check $(LOG)"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   list these targets"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q '\*\*\* FAILED \*\*\*' $(LOG); then echo "Simulation reported failure"; exit 1; fi
	@grep -q '\*\*\* PASSED \*\*\*' $(LOG) || { echo "No result found in $(LOG)"; exit 1; }

clean:
	rm -rf $(OBJ_DIR) $(LOG)
